// File: design/s16_cfg.svh
/* bus widths, wait limit and latch reset value for the System 16A bus slave
   included by the package and by any module that needs the limits */
`ifndef S16_CFG_SVH
`define S16_CFG_SVH

// bus widths
`define S16_ADDR_W 24       // byte address
`define S16_DATA_W 16
`define S16_BYTE_W 8        // cabinet and latch ports

// wait states on the memory port
`define S16_WAIT_W 5        // must hold S16_WAIT_LIMIT
`define S16_WAIT_LIMIT 16   // cycles before the bus error fires

// 8255 style latches come up all ones
`define S16_LATCH_RST 8'hff

`endif

// File: design/s16_pkg.sv
/* types shared by the System 16A bus slave and its testbench
   import with s16_pkg::* inside a module body */
`include "s16_cfg.svh"

package s16_pkg;

    typedef logic [`S16_ADDR_W-1:0] addr_t;
    typedef logic [`S16_DATA_W-1:0] word_t;
    typedef logic [`S16_BYTE_W-1:0] byte_t;
    typedef logic [`S16_WAIT_W-1:0] wait_cnt_t;

    // memory map regions
    typedef enum logic [3:0] {
        REG_NONE = 4'd0,
        REG_ROM  = 4'd1,
        REG_VRAM = 4'd2,
        REG_CHAR = 4'd3,    // text RAM
        REG_OBJ  = 4'd4,
        REG_PAL  = 4'd5,
        REG_RAM  = 4'd6,    // work RAM
        REG_IO   = 4'd7
    } region_e;

    typedef enum logic [1:0] {
        GAME_STD     = 2'd0,
        GAME_PASSSHT = 2'd1
    } game_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_IO   = 2'd1,
        ST_MEM  = 2'd2,
        ST_DONE = 2'd3
    } fsm_state_e;

    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        addr_t paddr;
        word_t pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic    valid;
        region_e region;
        addr_t   addr;
        logic    we;
        word_t   wdata;
        logic    ube;       // upper byte strobe
        logic    lbe;       // lower byte strobe
    } mem_req_t;

    // internal I/O access, one cycle pulse on rd or wr
    typedef struct packed {
        logic       rd;
        logic       wr;
        logic [1:0] sub_hi; // address bits 13:12
        logic [1:0] sub_lo; // address bits 2:1
        byte_t      wbyte;
    } io_acc_t;

    typedef struct packed {
        byte_t      joy1;
        byte_t      joy2;
        byte_t      joy3;
        byte_t      joy4;
        logic [3:0] start;
        logic [1:0] coin;
        logic       service;
        logic       dip_test;
    } cab_in_t;

endpackage

// File: design/s16_addr_decode.sv
/* System 16A memory map decoder, purely combinational
   sorts a byte address into one of the board regions */
`timescale 1ns/10ps

module s16_addr_decode (
    input  s16_pkg::addr_t   addr,
    output s16_pkg::region_e region
);
    import s16_pkg::*;

    logic [1:0] hi;     // bits 23:22
    logic [2:0] mid;    // bits 18:16

    assign hi  = addr[23:22];
    assign mid = addr[18:16];

    always_comb begin
        region = REG_NONE;
        case (hi)
            2'd0: begin
                if (!mid[2]) begin
                    region = REG_ROM;   // 00-03
                end
            end
            2'd1: begin
                if (mid[2]) begin
                    region = REG_OBJ;   // 44
                end else if (mid == 3'd0) begin
                    region = REG_VRAM;  // 40
                end else if (mid == 3'd1) begin
                    region = REG_CHAR;  // 41
                end
            end
            2'd2: begin
                if (mid[2]) begin
                    region = REG_PAL;   // 84
                end
            end
            default: begin
                if (mid[2:1] == 2'd2) begin
                    region = REG_IO;    // c4
                end else if (mid == 3'd7) begin
                    region = REG_RAM;   // c7
                end
                // c6 watchdog left unmapped
            end
        endcase
    end

endmodule

// File: design/s16_wait_timer.sv
/* wait state counter for the memory port
   start loads it, timeout holds at the limit until clear */
`timescale 1ns/10ps
`include "s16_cfg.svh"

module s16_wait_timer (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic clear,
    output logic timeout
);
    import s16_pkg::*;

    localparam wait_cnt_t LIMIT = wait_cnt_t'(`S16_WAIT_LIMIT);

    wait_cnt_t cnt;
    logic      running;

    assign running = (cnt != '0) && (cnt != LIMIT);
    assign timeout = (cnt == LIMIT);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (clear) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= wait_cnt_t'(1);  // first wait cycle
        end else if (running) begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// File: design/s16_cabinet_io.sv
/* cabinet input and DIP switch reads, including the Passing Shot
   four player port counter; read byte is registered one cycle after rd */
`timescale 1ns/10ps

module s16_cabinet_io (
    input  logic              clk,
    input  logic              rst,
    input  s16_pkg::io_acc_t  io_acc,
    input  s16_pkg::game_e    game,
    input  s16_pkg::cab_in_t  cab,
    input  s16_pkg::byte_t    dipsw_a,
    input  s16_pkg::byte_t    dipsw_b,
    output s16_pkg::byte_t    rd_byte
);
    import s16_pkg::*;

    logic [1:0] port_cnt;
    logic [1:0] cnt_nxt;
    logic       passsht;
    logic       in_rd;
    byte_t      port0;
    byte_t      pass_sel;
    byte_t      in_byte;

    // standard bit order of the joystick ports
    function automatic byte_t sort_joy(input byte_t j);
        return {j[1], j[0], j[3], j[2], j[7], j[5], j[4], j[6]};
    endfunction

    function automatic byte_t pass_joy(input byte_t j);
        return {j[7:4], j[1:0], j[3:2]};
    endfunction

    assign passsht = (game == GAME_PASSSHT);
    assign in_rd   = io_acc.rd && (io_acc.sub_hi == 2'd1);
    assign cnt_nxt = port_cnt + 2'd1;   // player picked by the advanced count

    assign port0 = {passsht ? cab.start[3:2] : 2'b11,
                    cab.start[1:0], cab.service, cab.dip_test, cab.coin};

    always_comb begin
        case (cnt_nxt)
            2'd1:    pass_sel = pass_joy(cab.joy1);
            2'd2:    pass_sel = pass_joy(cab.joy2);
            2'd3:    pass_sel = pass_joy(cab.joy3);
            default: pass_sel = pass_joy(cab.joy4);
        endcase
    end

    always_comb begin
        case (io_acc.sub_lo)
            2'd0:    in_byte = port0;
            2'd1:    in_byte = passsht ? pass_sel : sort_joy(cab.joy1);
            2'd2:    in_byte = 8'hff;
            default: in_byte = sort_joy(cab.joy2);
        endcase
    end

    // Passing Shot multiplexes four players on port 1
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            port_cnt <= 2'd0;
        end else if (in_rd && passsht) begin
            if (io_acc.sub_lo == 2'd0) begin
                port_cnt <= 2'd0;
            end else if (io_acc.sub_lo == 2'd1) begin
                port_cnt <= cnt_nxt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (io_acc.rd) begin
            case (io_acc.sub_hi)
                2'd1:    rd_byte <= in_byte;
                2'd2:    rd_byte <= io_acc.sub_lo[0] ? dipsw_b : dipsw_a;   // A1 picks bank
                default: rd_byte <= 8'hff;
            endcase
        end
    end

endmodule

// File: design/s16_ppi_latch.sv
/* three 8255 style output latches with read back
   port A is the sound latch, B and C carry the video and sound controls */
`timescale 1ns/10ps
`include "s16_cfg.svh"

module s16_ppi_latch (
    input  logic              clk,
    input  logic              rst,
    input  s16_pkg::io_acc_t  io_acc,
    input  logic              snd_ack,
    output s16_pkg::byte_t    rd_byte,
    output s16_pkg::byte_t    snd_latch,
    output logic              flip,
    output logic              video_en,
    output logic              sound_en,
    output logic              colscr_en,
    output logic              rowscr_en,
    output logic              snd_irqn
);
    import s16_pkg::*;

    byte_t ppi_a;
    byte_t ppi_b;
    byte_t ppi_c;
    logic  sel;

    assign sel = (io_acc.sub_hi == 2'd0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ppi_a <= `S16_LATCH_RST;
            ppi_b <= `S16_LATCH_RST;
            ppi_c <= `S16_LATCH_RST;
        end else if (io_acc.wr && sel) begin
            case (io_acc.sub_lo)
                2'd0:    ppi_a <= io_acc.wbyte;
                2'd1:    ppi_b <= io_acc.wbyte;
                2'd2:    ppi_c <= io_acc.wbyte;
                default: ;  // mode word, outputs fixed
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (io_acc.rd && sel) begin
            case (io_acc.sub_lo)
                2'd0:    rd_byte <= ppi_a;
                2'd1:    rd_byte <= ppi_b;
                2'd2:    rd_byte <= {ppi_c[7], snd_ack, ppi_c[5:0]};  // C6 is an input
                default: rd_byte <= 8'hff;
            endcase
        end
    end

    assign snd_latch = ppi_a;
    assign flip      = ppi_b[7];
    assign sound_en  = ~ppi_b[5];
    assign video_en  = ppi_b[4];
    assign snd_irqn  = ppi_c[7];
    assign colscr_en = ~ppi_c[2];
    assign rowscr_en = ~ppi_c[1];

endmodule

// File: design/s16_vint_irq.sv
/* VBLANK interrupt request, set on a rising vint edge and cleared by ack */
`timescale 1ns/10ps

module s16_vint_irq (
    input  logic clk,
    input  logic rst,
    input  logic vint,
    input  logic ack,
    output logic irqn
);
    logic vint_s;   // sampled vint
    logic vint_d;   // previous sample
    logic vint_rise;

    assign vint_rise = vint_s && !vint_d;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vint_s <= 1'b0;
            vint_d <= 1'b0;
            irqn   <= 1'b1;
        end else begin
            vint_s <= vint;
            vint_d <= vint_s;
            if (ack) begin
                irqn <= 1'b1;   // ack wins over a new edge
            end else if (vint_rise) begin
                irqn <= 1'b0;
            end
        end
    end

endmodule

// File: design/s16_access_fsm.sv
/* sequences each APB transfer into an I/O access, a memory request or an error
   one wait state for I/O and unmapped, memory waits for ok or the timeout */
`timescale 1ns/10ps

module s16_access_fsm (
    input  logic              clk,
    input  logic              rst,
    input  s16_pkg::apb_req_t apb_req,
    output s16_pkg::apb_rsp_t apb_rsp,
    input  s16_pkg::region_e  region,
    output s16_pkg::mem_req_t mem_req,
    input  logic              mem_ok,
    input  s16_pkg::word_t    mem_rdata,
    output logic              timer_start,
    output logic              timer_clear,
    input  logic              timeout,
    output s16_pkg::io_acc_t  io_acc,
    input  s16_pkg::byte_t    cab_byte,
    input  s16_pkg::byte_t    ppi_byte
);
    import s16_pkg::*;

    fsm_state_e state;
    fsm_state_e state_nxt;
    region_e    region_q;
    addr_t      addr_q;
    word_t      wdata_q;
    word_t      rdata_q;
    logic       write_q;
    logic       err_q;
    logic       access;
    logic       io_sel;
    byte_t      io_byte;

    // first access phase cycle of a new transfer
    assign access      = apb_req.psel && apb_req.penable && (state == ST_IDLE);
    assign timer_start = access && (region != REG_NONE) && (region != REG_IO);
    assign timer_clear = (state == ST_DONE);
    assign io_sel      = (state == ST_IO) && (region_q == REG_IO);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (access) begin
                    state_nxt = timer_start ? ST_MEM : ST_IO;   // unmapped rides ST_IO
                end
            end
            ST_IO:   state_nxt = ST_DONE;
            ST_MEM: begin
                if (mem_ok || timeout) begin
                    state_nxt = ST_DONE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            region_q <= REG_NONE;
            write_q  <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            state <= state_nxt;
            if (access) begin
                region_q <= region;
                write_q  <= apb_req.pwrite;
                err_q    <= (region == REG_NONE);
            end else if (state == ST_MEM && !mem_ok && timeout) begin
                err_q <= 1'b1;  // no ok in time, bus error
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            addr_q  <= apb_req.paddr;
            wdata_q <= apb_req.pwdata;
        end
        if (state == ST_MEM && mem_ok) begin
            rdata_q <= mem_rdata;
        end
    end

    always_comb begin
        case (addr_q[13:12])
            2'd0:    io_byte = ppi_byte;
            2'd1:    io_byte = cab_byte;
            2'd2:    io_byte = cab_byte;    // DIP switches
            default: io_byte = 8'hff;
        endcase
    end

    always_comb begin
        mem_req.valid  = (state == ST_MEM);
        mem_req.region = region_q;
        mem_req.addr   = addr_q;
        mem_req.we     = write_q;
        mem_req.wdata  = wdata_q;
        mem_req.ube    = 1'b1;  // full words only
        mem_req.lbe    = 1'b1;
    end

    always_comb begin
        io_acc.rd     = io_sel && !write_q;
        io_acc.wr     = io_sel && write_q;
        io_acc.sub_hi = addr_q[13:12];
        io_acc.sub_lo = addr_q[2:1];
        io_acc.wbyte  = wdata_q[7:0];   // I/O sits on the low byte
    end

    always_comb begin
        apb_rsp.pready  = (state == ST_DONE);
        apb_rsp.pslverr = (state == ST_DONE) && err_q;
        apb_rsp.prdata  = (region_q == REG_IO) ? {8'hff, io_byte} : rdata_q;
    end

endmodule

// File: design/s16_main_top.sv
/* System 16A main board bus glue as an APB slave
   memory regions go out on one request port, I/O and the IRQ are local */
`timescale 1ns/10ps

module s16_main_top (
    input  logic              clk,
    input  logic              rst,
    input  s16_pkg::apb_req_t apb_req,
    output s16_pkg::apb_rsp_t apb_rsp,
    output s16_pkg::mem_req_t mem_req,
    input  logic              mem_ok,
    input  s16_pkg::word_t    mem_rdata,
    input  s16_pkg::game_e    game,
    input  s16_pkg::cab_in_t  cab,
    input  s16_pkg::byte_t    dipsw_a,
    input  s16_pkg::byte_t    dipsw_b,
    input  logic              snd_ack,
    input  logic              vint,
    input  logic              irq_ack,
    output logic              irqn,
    output s16_pkg::byte_t    snd_latch,
    output logic              flip,
    output logic              video_en,
    output logic              sound_en,
    output logic              colscr_en,
    output logic              rowscr_en,
    output logic              snd_irqn
);
    import s16_pkg::*;

    region_e region;
    logic    timer_start;
    logic    timer_clear;
    logic    timeout;
    io_acc_t io_acc;
    byte_t   cab_byte;
    byte_t   ppi_byte;

    s16_addr_decode s16_addr_decode_inst (
        .addr   (apb_req.paddr),
        .region (region)
    );

    s16_access_fsm s16_access_fsm_inst (
        .clk         (clk),
        .rst         (rst),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .region      (region),
        .mem_req     (mem_req),
        .mem_ok      (mem_ok),
        .mem_rdata   (mem_rdata),
        .timer_start (timer_start),
        .timer_clear (timer_clear),
        .timeout     (timeout),
        .io_acc      (io_acc),
        .cab_byte    (cab_byte),
        .ppi_byte    (ppi_byte)
    );

    s16_wait_timer s16_wait_timer_inst (
        .clk     (clk),
        .rst     (rst),
        .start   (timer_start),
        .clear   (timer_clear),
        .timeout (timeout)
    );

    s16_cabinet_io s16_cabinet_io_inst (
        .clk     (clk),
        .rst     (rst),
        .io_acc  (io_acc),
        .game    (game),
        .cab     (cab),
        .dipsw_a (dipsw_a),
        .dipsw_b (dipsw_b),
        .rd_byte (cab_byte)
    );

    s16_ppi_latch s16_ppi_latch_inst (
        .clk       (clk),
        .rst       (rst),
        .io_acc    (io_acc),
        .snd_ack   (snd_ack),
        .rd_byte   (ppi_byte),
        .snd_latch (snd_latch),
        .flip      (flip),
        .video_en  (video_en),
        .sound_en  (sound_en),
        .colscr_en (colscr_en),
        .rowscr_en (rowscr_en),
        .snd_irqn  (snd_irqn)
    );

    s16_vint_irq s16_vint_irq_inst (
        .clk  (clk),
        .rst  (rst),
        .vint (vint),
        .ack  (irq_ack),
        .irqn (irqn)
    );

endmodule

// File: test/s16_main_chk.sv
/* APB and memory port handshake assertions, bound into the bus slave top level */
`timescale 1ns/10ps

module s16_main_chk (
    input logic              clk,
    input logic              rst,
    input s16_pkg::apb_rsp_t apb_rsp,
    input s16_pkg::mem_req_t mem_req,
    input logic              mem_ok
);
    int fail_count = 0;

    err_needs_ready: assert property (@(posedge clk) disable iff (rst)
        apb_rsp.pslverr |-> apb_rsp.pready)
        else begin
            $error("pslverr seen without pready");
            fail_count++;
        end

    // a timeout may only drop valid while the request waits for ok
    mem_req_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_req.valid && !mem_ok) |=> (!mem_req.valid || $stable(mem_req)))
        else begin
            $error("memory request changed while waiting for ok");
            fail_count++;
        end

    valid_drops_after_ok: assert property (@(posedge clk) disable iff (rst)
        (mem_req.valid && mem_ok) |=> !mem_req.valid)
        else begin
            $error("valid still high the cycle after mem_ok");
            fail_count++;
        end

    ready_single_cycle: assert property (@(posedge clk) disable iff (rst)
        apb_rsp.pready |=> !apb_rsp.pready)
        else begin
            $error("pready held for more than one cycle");
            fail_count++;
        end

endmodule

bind s16_main_top s16_main_chk s16_main_chk_inst (
    .clk     (clk),
    .rst     (rst),
    .apb_rsp (apb_rsp),
    .mem_req (mem_req),
    .mem_ok  (mem_ok)
);

// File: test/s16_main_tb.sv
/* directed testbench for the System 16A bus slave
   APB master tasks, a memory responder and one task per checked behavior */
`timescale 1ns/10ps
`include "s16_cfg.svh"

module s16_main_tb;
    import s16_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int DRV        = 1;      // input drive delay after the rising edge
    localparam int NUM_TESTS  = 6;
    localparam int MAX_WAIT   = 64;     // handshake limit in cycles

    logic     clk = 1'b0;
    logic     rst;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    mem_req_t mem_req;
    logic     mem_ok;
    word_t    mem_rdata;
    game_e    game;
    cab_in_t  cab;
    byte_t    dipsw_a;
    byte_t    dipsw_b;
    logic     snd_ack;
    logic     vint;
    logic     irq_ack;
    logic     irqn;
    byte_t    snd_latch;
    logic     flip;
    logic     video_en;
    logic     sound_en;
    logic     colscr_en;
    logic     rowscr_en;
    logic     snd_irqn;

    integer   seed = 94;
    int       req_count = 0;    // rising edges of mem_req.valid
    logic     valid_d = 1'b0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    s16_main_top s16_main_top_inst (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .mem_req   (mem_req),
        .mem_ok    (mem_ok),
        .mem_rdata (mem_rdata),
        .game      (game),
        .cab       (cab),
        .dipsw_a   (dipsw_a),
        .dipsw_b   (dipsw_b),
        .snd_ack   (snd_ack),
        .vint      (vint),
        .irq_ack   (irq_ack),
        .irqn      (irqn),
        .snd_latch (snd_latch),
        .flip      (flip),
        .video_en  (video_en),
        .sound_en  (sound_en),
        .colscr_en (colscr_en),
        .rowscr_en (rowscr_en),
        .snd_irqn  (snd_irqn)
    );

    always @(negedge clk) begin
        valid_d <= mem_req.valid;
        if (mem_req.valid && !valid_d) begin
            req_count <= req_count + 1;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAIL at %0t: %s, got %0h expected %0h", $time, what, got, exp));
        end
    endtask

    // joystick bit taken for output bits 7 down to 0
    function automatic byte_t joy_std_order(input byte_t j);
        int    src [8] = '{1, 0, 3, 2, 7, 5, 4, 6};
        byte_t o;
        int    i;
        for (i = 0; i < 8; i++) begin
            o[7 - i] = j[src[i]];
        end
        return o;
    endfunction

    function automatic byte_t joy_pass_order(input byte_t j);
        int    src [8] = '{7, 6, 5, 4, 1, 0, 3, 2};
        byte_t o;
        int    i;
        for (i = 0; i < 8; i++) begin
            o[7 - i] = j[src[i]];
        end
        return o;
    endfunction

    // one APB transfer with waits counted from the first access phase cycle
    task automatic apb_xfer(input logic wr, input addr_t addr, input word_t wdata,
                            output word_t rdata, output logic err, output int waits);
        @(posedge clk);
        #DRV;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #DRV;
        apb_req.penable = 1'b1;
        waits = 0;
        do begin
            @(posedge clk);
            #DRV;
            waits++;
            if (waits > MAX_WAIT) begin
                abort_run($sformatf("no pready from the DUT for address %06h", addr));
            end
        end while (!apb_rsp.pready);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        #DRV;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input addr_t addr, input word_t data,
                             output logic err, output int waits);
        word_t unused;
        apb_xfer(1'b1, addr, data, unused, err, waits);
    endtask

    task automatic apb_read(input addr_t addr, output word_t data,
                            output logic err, output int waits);
        apb_xfer(1'b0, addr, '0, data, err, waits);
    endtask

    // waits for valid, then answers with ok after a random delay or not at all
    task automatic mem_respond(input word_t data, input logic give_ok,
                               output mem_req_t seen, output int delay);
        int n;
        n     = 0;
        delay = 0;
        while (!mem_req.valid) begin
            @(posedge clk);
            #DRV;
            n++;
            if (n > MAX_WAIT) begin
                abort_run("the DUT never raised a memory request");
            end
        end
        seen = mem_req;
        if (give_ok) begin
            delay = {$random(seed)} % 6;
            repeat (delay) begin
                @(posedge clk);
                #DRV;
            end
            mem_ok    = 1'b1;
            mem_rdata = data;
            @(posedge clk);
            #DRV;
            mem_ok = 1'b0;
        end
    endtask

    task automatic io_read_check(input addr_t addr, input byte_t exp, input string what);
        word_t rdata;
        logic  err;
        int    waits;
        apb_read(addr, rdata, err, waits);
        check_eq(rdata, {8'hff, exp}, what);
        check_eq(err, 1'b0, {what, " pslverr"});
        check_eq(waits, 2, {what, " wait cycles"});
    endtask

    task automatic io_write(input addr_t addr, input byte_t data, input string what);
        logic err;
        int   waits;
        apb_write(addr, {8'h00, data}, err, waits);
        check_eq(err, 1'b0, {what, " pslverr"});
        check_eq(waits, 2, {what, " wait cycles"});
    endtask

    task automatic check_reset_values();
        check_eq(irqn, 1'b1, "irqn after reset");
        check_eq(snd_latch, 8'hff, "snd_latch after reset");
        check_eq(flip, 1'b1, "flip after reset");
        check_eq(video_en, 1'b1, "video_en after reset");
        check_eq(sound_en, 1'b0, "sound_en after reset");
        check_eq(colscr_en, 1'b0, "colscr_en after reset");
        check_eq(rowscr_en, 1'b0, "rowscr_en after reset");
        check_eq(snd_irqn, 1'b1, "snd_irqn after reset");
        check_eq(apb_rsp.pready, 1'b0, "pready after reset");
        check_eq(mem_req.valid, 1'b0, "mem valid after reset");
    endtask

    task automatic decode_memory_regions();
        addr_t    addrs [6] = '{24'h000100, 24'h400020, 24'h410040,
                                24'h440010, 24'h840002, 24'hc70008};
        region_e  regs [6]  = '{REG_ROM, REG_VRAM, REG_CHAR, REG_OBJ, REG_PAL, REG_RAM};
        mem_req_t seen;
        word_t    data;
        word_t    rdata;
        logic     err;
        int       waits;
        int       delay;
        int       cnt0;
        int       i;
        for (i = 0; i < 6; i++) begin
            data = $random(seed);
            cnt0 = req_count;
            fork
                apb_read(addrs[i], rdata, err, waits);
                mem_respond(data, 1'b1, seen, delay);
            join
            check_eq(seen.region, regs[i], $sformatf("region of %06h", addrs[i]));
            check_eq(seen.addr, addrs[i], "memory request address");
            check_eq(seen.we, 1'b0, "memory read strobe");
            check_eq(req_count, cnt0 + 1, "one request per read");
            check_eq(rdata, data, "memory read data");
            check_eq(err, 1'b0, "memory read pslverr");
            check_eq(waits, delay + 2, "pready one cycle after ok");
        end
        fork
            apb_write(24'hc70010, 16'hbeef, err, waits);
            mem_respond(16'h0000, 1'b1, seen, delay);
        join
        check_eq(seen.we, 1'b1, "work RAM write strobe");
        check_eq(seen.wdata, 16'hbeef, "work RAM write data");
        check_eq(seen.ube, 1'b1, "work RAM write upper byte strobe");
        check_eq(seen.lbe, 1'b1, "work RAM write lower byte strobe");
        check_eq(err, 1'b0, "work RAM write pslverr");
        // watchdog select is unmapped
        cnt0 = req_count;
        apb_read(24'hc60000, rdata, err, waits);
        check_eq(err, 1'b1, "unmapped read pslverr");
        check_eq(waits, 2, "unmapped read wait cycles");
        check_eq(req_count, cnt0, "no memory request for unmapped");
        fork
            apb_read(24'h000200, rdata, err, waits);
            mem_respond(16'h0000, 1'b0, seen, delay);
        join
        check_eq(err, 1'b1, "missing ok pslverr");
        check_eq(waits, `S16_WAIT_LIMIT + 1, "missing ok timeout cycles");
    endtask

    task automatic exercise_latches();
        byte_t a = 8'h5a;
        byte_t b = 8'h40;
        byte_t c = 8'h79;
        io_write(24'hc40000, a, "latch A write");
        check_eq(snd_latch, a, "snd_latch");
        io_write(24'hc40002, b, "latch B write");
        check_eq(flip, b[7], "flip");
        check_eq(sound_en, !b[5], "sound_en");
        check_eq(video_en, b[4], "video_en");
        io_write(24'hc40004, c, "latch C write");
        check_eq(snd_irqn, c[7], "snd_irqn");
        check_eq(colscr_en, !c[2], "colscr_en");
        check_eq(rowscr_en, !c[1], "rowscr_en");
        io_read_check(24'hc40000, a, "latch A read");
        io_read_check(24'hc40002, b, "latch B read");
        snd_ack = 1'b1;
        io_read_check(24'hc40004, {c[7], 1'b1, c[5:0]}, "latch C read, ack high");
        snd_ack = 1'b0;
        io_read_check(24'hc40004, {c[7], 1'b0, c[5:0]}, "latch C read, ack low");
    endtask

    task automatic read_std_cabinet();
        game         = GAME_STD;
        cab.joy1     = 8'ha6;
        cab.joy2     = 8'h5b;
        cab.start    = 4'b1001;   // upper starts ignored here
        cab.coin     = 2'b10;
        cab.service  = 1'b1;
        cab.dip_test = 1'b0;
        dipsw_a      = 8'hc3;
        dipsw_b      = 8'h2e;
        io_read_check(24'hc41000, {2'b11, cab.start[1:0], cab.service, cab.dip_test,
                                   cab.coin[1], cab.coin[0]}, "port 0");
        io_read_check(24'hc41002, joy_std_order(cab.joy1), "port 1");
        io_read_check(24'hc41004, 8'hff, "port 2");
        io_read_check(24'hc41006, joy_std_order(cab.joy2), "port 3");
        io_read_check(24'hc42000, dipsw_a, "DIP A");
        io_read_check(24'hc42002, dipsw_b, "DIP B");
    endtask

    task automatic cycle_passsht_players();
        word_t rdata;
        logic  err;
        int    waits;
        game      = GAME_PASSSHT;
        cab.joy1  = 8'h1e;
        cab.joy2  = 8'hc5;
        cab.joy3  = 8'h72;
        cab.joy4  = 8'hb9;
        cab.start = 4'b0110;
        // leave the player counter off zero so the port 0 read has to clear it
        apb_read(24'hc41002, rdata, err, waits);
        io_read_check(24'hc41000, {cab.start[3:2], cab.start[1:0], cab.service,
                                   cab.dip_test, cab.coin[1], cab.coin[0]}, "pass port 0");
        io_read_check(24'hc41002, joy_pass_order(cab.joy1), "pass player 1");
        io_read_check(24'hc41002, joy_pass_order(cab.joy2), "pass player 2");
        io_read_check(24'hc41002, joy_pass_order(cab.joy3), "pass player 3");
        io_read_check(24'hc41002, joy_pass_order(cab.joy4), "pass player 4");
        game = GAME_STD;
    endtask

    task automatic pulse_vblank_irq();
        vint = 1'b1;
        @(posedge clk);
        #DRV;
        check_eq(irqn, 1'b1, "irqn one cycle after vint edge");
        @(posedge clk);
        #DRV;
        check_eq(irqn, 1'b0, "irqn two cycles after vint edge");
        repeat (4) @(posedge clk);
        #DRV;
        check_eq(irqn, 1'b0, "irqn held until ack");
        irq_ack = 1'b1;
        @(posedge clk);
        #DRV;
        irq_ack = 1'b0;
        check_eq(irqn, 1'b1, "irqn after ack");
        repeat (6) @(posedge clk);
        #DRV;
        check_eq(irqn, 1'b1, "no retrigger on level vint");
        vint = 1'b0;
        repeat (3) @(posedge clk);
        #DRV;
        check_eq(irqn, 1'b1, "irqn after vint falls");
    endtask

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        rst       = 1'b1;
        apb_req   = '0;
        mem_ok    = 1'b0;
        mem_rdata = '0;
        game      = GAME_STD;
        cab       = '0;
        dipsw_a   = 8'hff;
        dipsw_b   = 8'hff;
        snd_ack   = 1'b0;
        vint      = 1'b0;
        irq_ack   = 1'b0;
        repeat (5) @(posedge clk);
        #DRV;
        rst = 1'b0;
        check_reset_values();
        decode_memory_regions();
        exercise_latches();
        read_std_cabinet();
        cycle_passsht_players();
        pulse_vblank_irq();
        if (s16_main_top_inst.s16_main_chk_inst.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+design
design/s16_pkg.sv
design/s16_addr_decode.sv
design/s16_wait_timer.sv
design/s16_cabinet_io.sv
design/s16_ppi_latch.sv
design/s16_vint_irq.sv
design/s16_access_fsm.sv
design/s16_main_top.sv
test/s16_main_chk.sv
test/s16_main_tb.sv
